//--- include/buf_params.svh
/* sizing of the sample buffer and the word addresses of its registers */
`ifndef BUF_PARAMS_SVH
`define BUF_PARAMS_SVH

// capture geometry
`define BUF_CHANNELS 2
`define BUF_DEPTH 16
`define BUF_DATA_W 16
`define BUF_MODE_W 1
`define BUF_ADDR_W 5

// wishbone register word addresses
`define BUF_REG_CTRL 3'd0
`define BUF_REG_MODE 3'd1
`define BUF_REG_CAP_RST 3'd2
`define BUF_REG_DMA_RST 3'd3
`define BUF_REG_DMA_START 3'd4
`define BUF_REG_DEPTH0 3'd5
`define BUF_REG_DEPTH1 3'd6
`define BUF_REG_STATUS 3'd7

`endif

//--- design/buf_pkg.sv
/*
 * shared types of the sample buffer: capture state, command flags,
 * per-channel write depth and register index
 */
`include "buf_params.svh"

package buf_pkg;

  typedef enum logic [1:0] {
    IDLE,
    ARMED,
    CAPTURING,
    DONE
  } capture_state_e;

  // single-cycle pulses from the register block
  typedef struct packed {
    logic arm;
    logic sw_start;
    logic sw_stop;
    logic cap_reset;
    logic dma_reset;
    logic dma_start;
  } cmd_t;

  // wide enough for one channel owning the whole memory
  typedef logic [$clog2(`BUF_DEPTH * `BUF_CHANNELS + 1)-1:0] depth_t;

  typedef logic [2:0] reg_idx_t;

endpackage

//--- design/buf_ifs.sv
/*
 * control and depth/status interfaces between the register block
 * and the capture and readout engines
 */
`include "buf_params.svh"

interface buf_ctrl_if;
  buf_pkg::cmd_t cmd;
  logic [`BUF_MODE_W-1:0] banking_mode;

  modport decode (
    output cmd,
    output banking_mode
  );

  modport engine (
    input cmd,
    input banking_mode
  );
endinterface

interface buf_depth_if;
  buf_pkg::depth_t depth [`BUF_CHANNELS];
  logic done;
  buf_pkg::capture_state_e capture_state;
  logic dma_busy;

  modport capture (
    output depth,
    output done,
    output capture_state
  );

  // readout walks the depths and reports its own activity
  modport readout (
    input depth,
    input capture_state,
    output dma_busy
  );

  modport status (
    input depth,
    input done,
    input capture_state,
    input dma_busy
  );
endinterface

//--- design/reg_decode.sv
/* wishbone classic slave: command pulses, banking mode register, depth and status reads */
`include "buf_params.svh"

module reg_decode (
  input  logic                   ps_clk,
  input  logic                   adc_reset,
  input  logic                   wb_cyc,
  input  logic                   wb_stb,
  input  logic                   wb_we,
  input  buf_pkg::reg_idx_t      wb_adr,
  input  logic [`BUF_DATA_W-1:0] wb_dat_w,
  output logic [`BUF_DATA_W-1:0] wb_dat_r,
  output logic                   wb_ack,
  buf_ctrl_if.decode             ctrl,
  buf_depth_if.status            stat,
  input  logic                   full
);

  localparam int CH = `BUF_CHANNELS;

  logic req;
  logic wr;
  logic [`BUF_DATA_W-1:0] rdata;
  buf_pkg::depth_t depth_q [CH];

  // a held stb gets a single ack
  assign req = wb_cyc && wb_stb && !wb_ack;
  assign wr = req && wb_we;

  always_ff @(posedge ps_clk) begin
    if (adc_reset) begin
      wb_ack <= 1'b0;
      ctrl.cmd <= '0;
      ctrl.banking_mode <= '0;
      for (int c = 0; c < CH; c++) begin
        depth_q[c] <= '0;
      end
    end else begin
      wb_ack <= req;
      ctrl.cmd <= '0;
      if (stat.done) begin
        depth_q <= stat.depth;
      end
      if (wr) begin
        case (wb_adr)
          `BUF_REG_CTRL: begin
            ctrl.cmd.arm <= wb_dat_w[2];
            ctrl.cmd.sw_start <= wb_dat_w[1];
            ctrl.cmd.sw_stop <= wb_dat_w[0];
          end
          `BUF_REG_MODE: begin
            // mode is frozen once a capture is under way
            if (stat.capture_state == buf_pkg::IDLE) begin
              ctrl.banking_mode <= wb_dat_w[`BUF_MODE_W-1:0];
            end
          end
          `BUF_REG_CAP_RST: begin
            ctrl.cmd.cap_reset <= 1'b1;
            for (int c = 0; c < CH; c++) begin
              depth_q[c] <= '0;
            end
          end
          `BUF_REG_DMA_RST: ctrl.cmd.dma_reset <= 1'b1;
          `BUF_REG_DMA_START: ctrl.cmd.dma_start <= 1'b1;
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    rdata = '0;
    case (wb_adr)
      `BUF_REG_DEPTH0: rdata = `BUF_DATA_W'(depth_q[0]);
      `BUF_REG_DEPTH1: rdata = `BUF_DATA_W'(depth_q[1]);
      // status bits from mode down to capture state
      `BUF_REG_STATUS: begin
        rdata = `BUF_DATA_W'({ctrl.banking_mode, stat.dma_busy, full, stat.capture_state});
      end
      default: ;
    endcase
  end

  always_ff @(posedge ps_clk) begin
    if (req && !wb_we) begin
      wb_dat_r <= rdata;
    end
  end

  // depth latch relies on the completion pulse arriving in DONE
  depth_latch_in_done: assert property (@(posedge ps_clk) disable iff (adc_reset)
    stat.done |-> stat.capture_state == buf_pkg::DONE);

endmodule

//--- design/capture_engine.sv
/*
 * capture FSM, per-channel depth counters and holding rings,
 * round-robin serialisation onto the single memory write port
 */
`include "buf_params.svh"

module capture_engine (
  input  logic                                       ps_clk,
  input  logic                                       adc_reset,
  input  logic [`BUF_CHANNELS-1:0][`BUF_DATA_W-1:0] smp_data,
  input  logic [`BUF_CHANNELS-1:0]                   smp_valid,
  input  logic                                       hw_start,
  input  logic                                       hw_stop,
  buf_ctrl_if.engine                                 ctrl,
  buf_depth_if.capture                               dep,
  output logic                                       wr_en,
  output logic [`BUF_ADDR_W-1:0]                     wr_addr,
  output logic [`BUF_DATA_W-1:0]                     wr_data,
  output logic                                       full,
  output logic                                       depth_event
);

  localparam int CH = `BUF_CHANNELS;
  localparam int D = `BUF_DEPTH;
  localparam int LOG_D = $clog2(D);
  localparam int CH_W = (CH > 1) ? $clog2(CH) : 1;

  buf_pkg::capture_state_e state;
  buf_pkg::capture_state_e state_next;
  buf_pkg::depth_t cnt [CH];
  buf_pkg::depth_t wcnt [CH];
  buf_pkg::depth_t limit;
  logic [`BUF_DATA_W-1:0] hold [CH][D];
  logic [`BUF_ADDR_W-1:0] base [CH];
  logic [CH-1:0] accept;
  logic [CH-1:0] pending;
  logic hit_limit;
  logic [CH_W-1:0] rr;
  logic [CH_W-1:0] sel;

  assign limit = buf_pkg::depth_t'(D) << ctrl.banking_mode;

  always_comb begin
    hit_limit = 1'b0;
    for (int c = 0; c < CH; c++) begin
      accept[c] = (state == buf_pkg::CAPTURING) && smp_valid[c] &&
                  (c < (CH >> ctrl.banking_mode)) && (cnt[c] < limit);
      pending[c] = (wcnt[c] != cnt[c]);
      base[c] = `BUF_ADDR_W'(c) << (LOG_D + ctrl.banking_mode);
      // full is judged on the count after this cycle's store
      if (accept[c] && (cnt[c] + buf_pkg::depth_t'(1) == limit)) begin
        hit_limit = 1'b1;
      end
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      buf_pkg::IDLE: begin
        if (ctrl.cmd.sw_start) begin
          state_next = buf_pkg::CAPTURING;
        end else if (ctrl.cmd.arm) begin
          state_next = buf_pkg::ARMED;
        end
      end
      buf_pkg::ARMED: begin
        if (ctrl.cmd.sw_start || hw_start) begin
          state_next = buf_pkg::CAPTURING;
        end
      end
      buf_pkg::CAPTURING: begin
        if (ctrl.cmd.sw_stop || hw_stop || hit_limit) begin
          state_next = buf_pkg::DONE;
        end
      end
      default: ;
    endcase
    if (ctrl.cmd.cap_reset) begin
      state_next = buf_pkg::IDLE;
    end
  end

  // pick the first pending channel at or after the round-robin pointer
  always_comb begin
    sel = rr;
    wr_en = 1'b0;
    for (int i = CH - 1; i >= 0; i--) begin
      if (pending[(int'(rr) + i) % CH]) begin
        sel = CH_W'((int'(rr) + i) % CH);
        wr_en = 1'b1;
      end
    end
    wr_addr = base[sel] + `BUF_ADDR_W'(wcnt[sel]);
    wr_data = hold[sel][wcnt[sel][LOG_D-1:0]];
  end

  always_ff @(posedge ps_clk) begin
    if (adc_reset) begin
      state <= buf_pkg::IDLE;
      full <= 1'b0;
      depth_event <= 1'b0;
      rr <= '0;
      for (int c = 0; c < CH; c++) begin
        cnt[c] <= '0;
        wcnt[c] <= '0;
      end
    end else begin
      state <= state_next;
      depth_event <= (state_next == buf_pkg::DONE) && (state != buf_pkg::DONE);
      if (ctrl.cmd.cap_reset) begin
        full <= 1'b0;
        for (int c = 0; c < CH; c++) begin
          cnt[c] <= '0;
          wcnt[c] <= '0;
        end
      end else begin
        if (hit_limit) begin
          full <= 1'b1;
        end
        for (int c = 0; c < CH; c++) begin
          if (accept[c]) begin
            cnt[c] <= cnt[c] + 1'b1;
          end
        end
        if (wr_en) begin
          wcnt[sel] <= wcnt[sel] + 1'b1;
          rr <= (sel == CH_W'(CH - 1)) ? '0 : sel + 1'b1;
        end
      end
    end
  end

  // ring slot is the sample index modulo the bank depth
  always_ff @(posedge ps_clk) begin
    for (int c = 0; c < CH; c++) begin
      if (accept[c]) begin
        hold[c][cnt[c][LOG_D-1:0]] <= smp_data[c];
      end
    end
  end

  assign dep.depth = cnt;
  assign dep.done = depth_event;
  assign dep.capture_state = state;

  write_in_region: assert property (@(posedge ps_clk) disable iff (adc_reset)
    wr_en |-> (wr_addr >= base[sel]) && (wr_addr < base[sel] + limit));

endmodule

//--- design/sample_ram.sv
/* sample memory over all banks, one write port and a registered read port */
`include "buf_params.svh"

module sample_ram (
  input  logic                   ps_clk,
  input  logic                   wr_en,
  input  logic [`BUF_ADDR_W-1:0] wr_addr,
  input  logic [`BUF_DATA_W-1:0] wr_data,
  input  logic                   rd_en,
  input  logic [`BUF_ADDR_W-1:0] rd_addr,
  output logic [`BUF_DATA_W-1:0] rd_q
);

  localparam int WORDS = `BUF_CHANNELS * `BUF_DEPTH;

  logic [`BUF_DATA_W-1:0] mem [WORDS];

  always_ff @(posedge ps_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
    // one cycle read latency
    if (rd_en) begin
      rd_q <= mem[rd_addr];
    end
  end

endmodule

//--- design/readout_engine.sv
/* readout of the captured regions onto a valid/ready stream with last */
`include "buf_params.svh"

module readout_engine (
  input  logic                   ps_clk,
  input  logic                   adc_reset,
  buf_ctrl_if.engine             ctrl,
  buf_depth_if.readout           dep,
  output logic                   rd_en,
  output logic [`BUF_ADDR_W-1:0] rd_addr,
  input  logic [`BUF_DATA_W-1:0] rd_q,
  output logic [`BUF_DATA_W-1:0] rd_data,
  output logic                   rd_valid,
  output logic                   rd_last,
  input  logic                   rd_ready
);

  localparam int CH = `BUF_CHANNELS;
  localparam int LOG_D = $clog2(`BUF_DEPTH);
  localparam int CH_W = (CH > 1) ? $clog2(CH) : 1;

  logic busy;
  logic [CH_W-1:0] cur_ch;
  buf_pkg::depth_t cur_idx;
  buf_pkg::depth_t issued;
  buf_pkg::depth_t total;
  logic inflight;
  logic inflight_last;
  logic pf_valid;
  logic pf_last;
  logic [`BUF_DATA_W-1:0] pf_data;
  logic [1:0] occ;
  logic pop;
  logic start;
  logic abort;
  logic more;
  logic in_word;
  logic issue;
  logic last_word;
  logic load_out;
  logic take_pf;

  always_comb begin
    total = '0;
    for (int c = 0; c < CH; c++) begin
      if (c < (CH >> ctrl.banking_mode)) begin
        total = total + dep.depth[c];
      end
    end
  end

  assign pop = rd_valid && rd_ready;
  // empty capture gives no stream at all
  assign start = ctrl.cmd.dma_start && (dep.capture_state == buf_pkg::DONE) &&
                 !busy && (total != '0);
  assign abort = busy && (ctrl.cmd.dma_reset || (dep.capture_state != buf_pkg::DONE));
  assign more = busy && (issued != total);
  assign in_word = cur_idx < dep.depth[cur_ch];
  assign last_word = (issued + buf_pkg::depth_t'(1)) == total;

  // output register, prefetch slot and read in flight share two entries
  assign occ = 2'(rd_valid) + 2'(pf_valid) + 2'(inflight);
  assign issue = more && in_word && !abort && ((occ - 2'(pop)) < 2'd2);

  assign rd_en = issue;
  assign rd_addr = (`BUF_ADDR_W'(cur_ch) << (LOG_D + ctrl.banking_mode)) +
                   `BUF_ADDR_W'(cur_idx);

  assign load_out = !rd_valid || pop;
  assign take_pf = inflight && !(load_out && !pf_valid);

  always_ff @(posedge ps_clk) begin
    if (adc_reset) begin
      busy <= 1'b0;
      rd_valid <= 1'b0;
      rd_last <= 1'b0;
      pf_valid <= 1'b0;
      inflight <= 1'b0;
      cur_ch <= '0;
      cur_idx <= '0;
      issued <= '0;
    end else if (abort) begin
      busy <= 1'b0;
      rd_valid <= 1'b0;
      rd_last <= 1'b0;
      pf_valid <= 1'b0;
      inflight <= 1'b0;
    end else begin
      if (start) begin
        busy <= 1'b1;
        cur_ch <= '0;
        cur_idx <= '0;
        issued <= '0;
      end else if (more) begin
        if (issue) begin
          cur_idx <= cur_idx + 1'b1;
          issued <= issued + 1'b1;
        end else if (!in_word) begin
          // next region once this channel is exhausted
          cur_ch <= cur_ch + 1'b1;
          cur_idx <= '0;
        end
      end
      inflight <= issue;
      if (load_out) begin
        if (pf_valid) begin
          rd_valid <= 1'b1;
          rd_last <= pf_last;
          pf_valid <= inflight;
        end else begin
          rd_valid <= inflight;
          rd_last <= inflight && inflight_last;
        end
      end else if (inflight) begin
        pf_valid <= 1'b1;
      end
      if (pop && rd_last) begin
        busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge ps_clk) begin
    inflight_last <= last_word;
    if (load_out) begin
      if (pf_valid) begin
        rd_data <= pf_data;
      end else if (inflight) begin
        rd_data <= rd_q;
      end
    end
    if (take_pf) begin
      pf_data <= rd_q;
      pf_last <= inflight_last;
    end
  end

  assign dep.dma_busy = busy;

  stable_under_backpressure: assert property (@(posedge ps_clk) disable iff (adc_reset)
    rd_valid && !rd_ready |=> !rd_valid || ($stable(rd_data) && $stable(rd_last)));

endmodule

//--- design/sample_buffer_top.sv
/* sample buffer top level: register block, capture, memory and readout */
`include "buf_params.svh"

module sample_buffer_top (
  input  logic                                       ps_clk,
  input  logic                                       adc_reset,
  input  logic                                       wb_cyc,
  input  logic                                       wb_stb,
  input  logic                                       wb_we,
  input  buf_pkg::reg_idx_t                          wb_adr,
  input  logic [`BUF_DATA_W-1:0]                     wb_dat_w,
  output logic [`BUF_DATA_W-1:0]                     wb_dat_r,
  output logic                                       wb_ack,
  input  logic [`BUF_CHANNELS-1:0][`BUF_DATA_W-1:0] smp_data,
  input  logic [`BUF_CHANNELS-1:0]                   smp_valid,
  input  logic                                       hw_start,
  input  logic                                       hw_stop,
  output logic                                       full,
  output logic                                       depth_event,
  output logic [`BUF_DATA_W-1:0]                     rd_data,
  output logic                                       rd_valid,
  output logic                                       rd_last,
  input  logic                                       rd_ready
);

  logic wr_en;
  logic [`BUF_ADDR_W-1:0] wr_addr;
  logic [`BUF_DATA_W-1:0] wr_data;
  logic rd_en;
  logic [`BUF_ADDR_W-1:0] rd_addr;
  logic [`BUF_DATA_W-1:0] rd_q;

  buf_ctrl_if ctrl_if ();
  buf_depth_if dep_if ();

  reg_decode u_reg_decode (
    .ps_clk,
    .adc_reset,
    .wb_cyc,
    .wb_stb,
    .wb_we,
    .wb_adr,
    .wb_dat_w,
    .wb_dat_r,
    .wb_ack,
    .ctrl (ctrl_if.decode),
    .stat (dep_if.status),
    .full
  );

  capture_engine u_capture (
    .ps_clk,
    .adc_reset,
    .smp_data,
    .smp_valid,
    .hw_start,
    .hw_stop,
    .ctrl (ctrl_if.engine),
    .dep (dep_if.capture),
    .wr_en,
    .wr_addr,
    .wr_data,
    .full,
    .depth_event
  );

  sample_ram u_ram (
    .ps_clk,
    .wr_en,
    .wr_addr,
    .wr_data,
    .rd_en,
    .rd_addr,
    .rd_q
  );

  readout_engine u_readout (
    .ps_clk,
    .adc_reset,
    .ctrl (ctrl_if.engine),
    .dep (dep_if.readout),
    .rd_en,
    .rd_addr,
    .rd_q,
    .rd_data,
    .rd_valid,
    .rd_last,
    .rd_ready
  );

endmodule

//--- tb/tb_sample_buffer.sv
/*
 * testbench for the sample buffer: wishbone register tasks, random samples,
 * capture model with per-channel expected data, readout stream checks
 */
`include "buf_params.svh"

module tb_sample_buffer;

  localparam int CH = `BUF_CHANNELS;
  localparam int DEPTH = `BUF_DEPTH;
  localparam int DW = `BUF_DATA_W;
  // two modes of fills up to 8 * limit cycles plus readouts at 3/4 ready duty and margin
  localparam int TIMEOUT_CYCLES = 20000;

  logic ps_clk;
  logic adc_reset;
  logic wb_cyc;
  logic wb_stb;
  logic wb_we;
  logic [2:0] wb_adr;
  logic [DW-1:0] wb_dat_w;
  logic [DW-1:0] wb_dat_r;
  logic wb_ack;
  logic [CH-1:0][DW-1:0] smp_data;
  logic [CH-1:0] smp_valid;
  logic hw_start;
  logic hw_stop;
  logic full;
  logic depth_event;
  logic [DW-1:0] rd_data;
  logic rd_valid;
  logic rd_last;
  logic rd_ready;

  int cycle_count = 0;
  int event_count = 0;
  int errors;
  int errors_at_start;
  int tests_run;
  int tests_failed;
  int mode;
  int active;
  int limit;
  int model_cnt [CH];
  logic [DW-1:0] model_mem [CH][CH*DEPTH];
  logic [DW-1:0] got_data [$];
  logic got_last [$];

  sample_buffer_top dut (.*);

  initial begin
    ps_clk = 1'b0;
    forever #20 ps_clk = ~ps_clk;
  end

  always @(posedge ps_clk) begin
    cycle_count <= cycle_count + 1;
    if (depth_event) begin
      event_count <= event_count + 1;
    end
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, the DUT stopped responding", cycle_count);
      $display("Checks failed");
      $finish;
    end
  end

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
    errors++;
  endtask

  task automatic report_problem(input string what);
    $display("error: %s", what);
    errors++;
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors == errors_at_start) begin
      $display("mode %0d, %s: pass", mode, name);
    end else begin
      $display("mode %0d, %s: %0d errors", mode, name, errors - errors_at_start);
      tests_failed++;
    end
    errors_at_start = errors;
  endtask

  // one classic cycle released on the negedge that sees ack
  task automatic write_reg(input logic [2:0] adr, input logic [DW-1:0] dat);
    @(negedge ps_clk);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we = 1'b1;
    wb_adr = adr;
    wb_dat_w = dat;
    do begin
      @(negedge ps_clk);
    end while (wb_ack !== 1'b1);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
  endtask

  task automatic read_reg(input logic [2:0] adr, output logic [DW-1:0] dat);
    @(negedge ps_clk);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we = 1'b0;
    wb_adr = adr;
    do begin
      @(negedge ps_clk);
    end while (wb_ack !== 1'b1);
    dat = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
  endtask

  task automatic wait_for_state(input buf_pkg::capture_state_e st);
    logic [DW-1:0] s;
    do begin
      read_reg(`BUF_REG_STATUS, s);
    end while (s[1:0] !== st);
  endtask

  task automatic wait_for_full();
    do begin
      @(negedge ps_clk);
    end while (full !== 1'b1);
  endtask

  task automatic pulse_hw_start();
    @(negedge ps_clk);
    hw_start = 1'b1;
    @(negedge ps_clk);
    hw_start = 1'b0;
  endtask

  task automatic pulse_hw_stop();
    @(negedge ps_clk);
    hw_stop = 1'b1;
    @(negedge ps_clk);
    hw_stop = 1'b0;
  endtask

  task automatic clear_model();
    for (int c = 0; c < CH; c++) begin
      model_cnt[c] = 0;
    end
  endtask

  function automatic int model_total();
    int t;
    t = 0;
    for (int c = 0; c < CH; c++) begin
      t += model_cnt[c];
    end
    return t;
  endfunction

  // random samples modelled as stored on the posedge that follows
  task automatic drive_samples(input int max_cycles, output bit hit);
    int n;
    n = 0;
    hit = 1'b0;
    while (n < max_cycles && !hit) begin
      @(negedge ps_clk);
      for (int c = 0; c < CH; c++) begin
        smp_data[c] = DW'($urandom);
        smp_valid[c] = 1'($urandom % 2);
        if (smp_valid[c] && c < active && model_cnt[c] < limit) begin
          model_mem[c][model_cnt[c]] = smp_data[c];
          model_cnt[c]++;
          if (model_cnt[c] == limit) begin
            hit = 1'b1;
          end
        end
      end
      n++;
    end
    @(negedge ps_clk);
    smp_valid = '0;
  endtask

  task automatic check_depths();
    logic [DW-1:0] d;
    for (int c = 0; c < CH; c++) begin
      read_reg(`BUF_REG_DEPTH0 + 3'(c), d);
      if (d !== DW'(model_cnt[c])) begin
        report_mismatch($sformatf("depth%0d", c), d, model_cnt[c]);
      end
    end
  endtask

  // collects popped words with ready chosen on each negedge
  task automatic stream_words(input int stop_after);
    bit held;
    bit ready;
    bit done;
    logic [DW-1:0] held_data;
    logic held_last;
    held = 1'b0;
    done = 1'b0;
    got_data.delete();
    got_last.delete();
    while (!done) begin
      @(negedge ps_clk);
      if (held && rd_valid !== 1'b1) begin
        report_problem("rd_valid dropped while rd_ready was low");
      end
      if (held && (rd_data !== held_data || rd_last !== held_last)) begin
        report_mismatch("rd_data under back-pressure", {rd_last, rd_data},
                        {held_last, held_data});
      end
      ready = ($urandom % 4) != 0;
      rd_ready = ready;
      held = rd_valid && !ready;
      held_data = rd_data;
      held_last = rd_last;
      if (rd_valid && ready) begin
        got_data.push_back(rd_data);
        got_last.push_back(rd_last);
        done = rd_last || (got_data.size() == stop_after);
      end
    end
    @(negedge ps_clk);
    rd_ready = 1'b0;
  endtask

  task automatic check_stream(input int want);
    logic [DW-1:0] exp [$];
    for (int c = 0; c < active; c++) begin
      for (int i = 0; i < model_cnt[c]; i++) begin
        exp.push_back(model_mem[c][i]);
      end
    end
    if (got_data.size() != want) begin
      report_mismatch("word count", got_data.size(), want);
    end
    for (int i = 0; i < got_data.size() && i < exp.size(); i++) begin
      if (got_data[i] !== exp[i]) begin
        report_mismatch($sformatf("rd_data word %0d", i), got_data[i], exp[i]);
      end
      if (got_last[i] !== (i == exp.size() - 1)) begin
        report_mismatch($sformatf("rd_last word %0d", i), got_last[i], i == exp.size() - 1);
      end
    end
  endtask

  task automatic run_mode(input int m);
    logic [DW-1:0] s;
    bit hit;
    int ev;
    int half;
    mode = m;
    active = CH >> m;
    limit = DEPTH << m;
    write_reg(`BUF_REG_CAP_RST, '0);
    write_reg(`BUF_REG_MODE, DW'(m));

    clear_model();
    ev = event_count;
    pulse_hw_start();
    write_reg(`BUF_REG_CTRL, 16'h1);
    check_depths();
    read_reg(`BUF_REG_STATUS, s);
    if (s[1:0] !== buf_pkg::IDLE) begin
      report_mismatch("status state", s[1:0], buf_pkg::IDLE);
    end
    if (full !== 1'b0) begin
      report_mismatch("full", full, 0);
    end
    if (event_count != ev) begin
      report_mismatch("depth_event count", event_count - ev, 0);
    end
    finish_test("hw start while not armed");

    write_reg(`BUF_REG_CTRL, 16'h4);
    wait_for_state(buf_pkg::ARMED);
    pulse_hw_start();
    wait_for_state(buf_pkg::CAPTURING);
    clear_model();
    ev = event_count;
    drive_samples(8 * limit, hit);
    if (!hit) begin
      report_problem("random samples never filled a channel");
    end
    wait_for_full();
    wait_for_state(buf_pkg::DONE);
    check_depths();
    if (event_count - ev != 1) begin
      report_mismatch("depth_event count", event_count - ev, 1);
    end
    finish_test("armed hw start until full");

    write_reg(`BUF_REG_CAP_RST, '0);
    wait_for_state(buf_pkg::IDLE);
    clear_model();
    if (full !== 1'b0) begin
      report_mismatch("full", full, 0);
    end
    check_depths();
    // mode write while capturing must not stick
    write_reg(`BUF_REG_CTRL, 16'h2);
    wait_for_state(buf_pkg::CAPTURING);
    write_reg(`BUF_REG_MODE, DW'(m ^ 1));
    read_reg(`BUF_REG_STATUS, s);
    if (s[4] !== 1'(m)) begin
      report_mismatch("status banking mode", s[4], m);
    end
    pulse_hw_stop();
    wait_for_state(buf_pkg::DONE);
    write_reg(`BUF_REG_CAP_RST, '0);
    wait_for_state(buf_pkg::IDLE);
    finish_test("capture reset");

    write_reg(`BUF_REG_CTRL, 16'h2);
    wait_for_state(buf_pkg::CAPTURING);
    clear_model();
    ev = event_count;
    drive_samples(DEPTH * 3 / 4, hit);
    write_reg(`BUF_REG_CTRL, 16'h1);
    wait_for_state(buf_pkg::DONE);
    check_depths();
    if (event_count - ev != 1) begin
      report_mismatch("depth_event count", event_count - ev, 1);
    end
    finish_test("sw start and stop");

    if (model_total() == 0) begin
      report_problem("capture window stored no samples, readout not run");
    end else begin
      half = (model_total() > 1) ? model_total() / 2 : 1;
      write_reg(`BUF_REG_DMA_START, '0);
      stream_words(half);
      check_stream(half);
      write_reg(`BUF_REG_DMA_RST, '0);
      read_reg(`BUF_REG_STATUS, s);
      if (s[3] !== 1'b0) begin
        report_mismatch("status dma_busy", s[3], 0);
      end
      if (rd_valid !== 1'b0) begin
        report_mismatch("rd_valid", rd_valid, 0);
      end
      write_reg(`BUF_REG_DMA_START, '0);
      stream_words(model_total());
      check_stream(model_total());
    end
    finish_test("readout with reset and restart");
  endtask

  initial begin
    void'($urandom(32'ha97b5c01));
    adc_reset = 1'b1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = '0;
    wb_dat_w = '0;
    smp_data = '0;
    smp_valid = '0;
    hw_start = 1'b0;
    hw_stop = 1'b0;
    rd_ready = 1'b0;
    errors = 0;
    errors_at_start = 0;
    tests_run = 0;
    tests_failed = 0;
    mode = 0;
    repeat (8) @(negedge ps_clk);
    adc_reset = 1'b0;
    if ({wb_ack, full, depth_event, rd_valid, rd_last} !== 5'b0) begin
      report_mismatch("outputs after reset", {wb_ack, full, depth_event, rd_valid, rd_last}, 0);
    end
    finish_test("outputs low after reset");
    run_mode(0);
    run_mode(1);
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- vlog.f
+incdir+include
design/buf_pkg.sv
design/buf_ifs.sv
design/reg_decode.sv
design/capture_engine.sv
design/sample_ram.sv
design/readout_engine.sv
design/sample_buffer_top.sv
tb/tb_sample_buffer.sv

//--- Makefile
TOP = tb_sample_buffer

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Checks failed" sim.log; then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "All checks passed" sim.log; then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
